// ==== Makefile ====
# Verilator build and run for the intCore pipeline testbench
VERILATOR ?= verilator
TOP ?= intCoreTb
RTL_TOP ?= intCore
LOG ?= run.log
SEED_ARGS ?= +verilator+seed+1
RUN_ARGS ?= +verilator+error+limit+100
OBJ_DIR ?= obj_dir
FILELIST ?= src.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) $(RUN_ARGS) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/decodeStage.sv ====
// decode stage: instruction register, field decode, immediates and register reads
// holds on a load-use hazard or a memory stall and feeds the execute register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input logic clk,
	input logic reset,
	input logic [rvPkg::xlen-1:0] instr,
	input logic instrValid,
	output logic instrReady,
	// valid bit on top, rd of the load below
	input logic [rvPkg::regAddrW:0] loadInExec,
	input logic memStall,
	memWbIf.sink wbPort,
	output logic exValid,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exUseImm,
	output logic exIsLui,
	output logic [2:0] exAluSel,
	output logic exAltOp,
	output logic [2:0] exFunct3,
	output logic [rvPkg::regAddrW-1:0] exRs1,
	output logic [rvPkg::regAddrW-1:0] exRs2,
	output logic [rvPkg::regAddrW-1:0] exRd,
	output logic [rvPkg::xlen-1:0] exRs1Data,
	output logic [rvPkg::xlen-1:0] exRs2Data,
	output logic [rvPkg::xlen-1:0] exImm
);

	rvPkg::instrWord instrQ;
	logic decValid;
	logic readyQ;
	logic isOp, isImm, isLui, isLoad, isStore;
	logic regWrite, useImm, altOp, usesRs2, loadUse;
	logic [2:0] aluSel;
	logic [rvPkg::xlen-1:0] imm;
	logic [rvPkg::regAddrW-1:0] rs1, rs2;
	logic [rvPkg::xlen-1:0] rs1Data, rs2Data;

	regFile uRegFile (
		.clk(clk),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.writeEn(wbPort.regWrite),
		.writeAddr(wbPort.rd),
		.writeData(wbPort.result),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	// opcode class and fields through the matching view
	assign isOp = instrQ.iView.opcode == rvPkg::opOp;
	assign isImm = instrQ.iView.opcode == rvPkg::opImm;
	assign isLui = instrQ.iView.opcode == rvPkg::opLui;
	assign isLoad = instrQ.iView.opcode == rvPkg::opLoad;
	assign isStore = instrQ.sView.opcode == rvPkg::opStore;
	assign rs1 = instrQ.iView.rs1;
	assign rs2 = instrQ.sView.rs2;
	assign regWrite = isOp || isImm || isLui || isLoad;
	assign usesRs2 = isOp || isStore;

	always_comb begin
		imm = '0;
		aluSel = rvPkg::aluAdd;
		altOp = 1'b0;
		useImm = isImm || isLoad || isStore;
		if (isImm || isLoad) begin
			imm = {{20{instrQ.iView.imm[11]}}, instrQ.iView.imm};
		end
		if (isStore) begin
			imm = {{20{instrQ.sView.immHi[6]}}, instrQ.sView.immHi, instrQ.sView.immLo};
		end
		// U immediate rebuilt from the upper I fields
		if (isLui) begin
			imm = {instrQ.iView.imm, instrQ.iView.rs1, instrQ.iView.funct3, 12'b0};
		end
		// bit 30 selects sub/sra
		if (isOp) begin
			aluSel = instrQ.iView.funct3;
			altOp = instrQ.sView.immHi[5];
		end
		// immediates have no subtract, only srai uses bit 30
		if (isImm) begin
			aluSel = instrQ.iView.funct3;
			altOp = (instrQ.iView.funct3 == rvPkg::aluSrl) && instrQ.sView.immHi[5];
		end
	end

	// a load in execute cannot forward in time, wait one cycle for it
	assign loadUse = decValid && loadInExec[rvPkg::regAddrW] &&
		(loadInExec[rvPkg::regAddrW-1:0] != '0) &&
		((!isLui && rs1 == loadInExec[rvPkg::regAddrW-1:0]) ||
		(usesRs2 && rs2 == loadInExec[rvPkg::regAddrW-1:0]));

	assign instrReady = readyQ && !memStall && !loadUse;

	always_ff @(posedge clk) begin
		if (!reset) begin
			readyQ <= 1'b0;
			decValid <= 1'b0;
		end else begin
			readyQ <= 1'b1;
			if (instrReady) begin
				decValid <= instrValid;
			end else if (!memStall && !loadUse) begin
				decValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instrReady && instrValid) begin
			instrQ <= instr;
		end
	end

	// execute register control, load-use leaves a bubble behind
	always_ff @(posedge clk) begin
		if (!reset) begin
			exValid <= 1'b0;
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
		end else if (!memStall) begin
			exValid <= decValid && !loadUse;
			exRegWrite <= decValid && !loadUse && regWrite;
			exMemRead <= decValid && !loadUse && isLoad;
			exMemWrite <= decValid && !loadUse && isStore;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			exUseImm <= useImm;
			exIsLui <= isLui;
			exAluSel <= aluSel;
			exAltOp <= altOp;
			exFunct3 <= instrQ.iView.funct3;
			exRs1 <= rs1;
			exRs2 <= rs2;
			exRd <= instrQ.iView.rd;
			exRs1Data <= rs1Data;
			exRs2Data <= rs2Data;
			exImm <= imm;
		end
	end

endmodule

`default_nettype wire

// ==== hw/execStage.sv ====
// execute stage: operand forwarding, ALU and the execute-to-memory register
`timescale 1ns/1ps
`default_nettype none

module execStage (
	input logic clk,
	input logic reset,
	input logic exValid,
	input logic exRegWrite,
	input logic exMemRead,
	input logic exMemWrite,
	input logic exUseImm,
	input logic exIsLui,
	input logic [2:0] exAluSel,
	input logic exAltOp,
	input logic [2:0] exFunct3,
	input logic [rvPkg::regAddrW-1:0] exRs1,
	input logic [rvPkg::regAddrW-1:0] exRs2,
	input logic [rvPkg::regAddrW-1:0] exRd,
	input logic [rvPkg::xlen-1:0] exRs1Data,
	input logic [rvPkg::xlen-1:0] exRs2Data,
	input logic [rvPkg::xlen-1:0] exImm,
	exMemIf.source memPort,
	memWbIf.sink wbPort,
	output logic [rvPkg::regAddrW:0] loadInExec
);

	logic memFwd, wbFwd;
	logic [rvPkg::xlen-1:0] opA, opB, srcB, aluOut;

	// memory stage results qualify unless they still wait on a load
	assign memFwd = memPort.valid && memPort.regWrite && !memPort.memRead &&
		(memPort.rd != '0);
	assign wbFwd = wbPort.regWrite && (wbPort.rd != '0);

	// youngest producer wins
	assign opA = (memFwd && memPort.rd == exRs1) ? memPort.aluResult :
		(wbFwd && wbPort.rd == exRs1) ? wbPort.result : exRs1Data;
	assign opB = (memFwd && memPort.rd == exRs2) ? memPort.aluResult :
		(wbFwd && wbPort.rd == exRs2) ? wbPort.result : exRs2Data;
	assign srcB = exUseImm ? exImm : opB;

	always_comb begin
		case (exAluSel)
			rvPkg::aluAdd: aluOut = exAltOp ? opA - srcB : opA + srcB;
			rvPkg::aluSll: aluOut = opA << srcB[4:0];
			rvPkg::aluSlt: aluOut = {31'b0, $signed(opA) < $signed(srcB)};
			rvPkg::aluSltu: aluOut = {31'b0, opA < srcB};
			rvPkg::aluXor: aluOut = opA ^ srcB;
			// arithmetic shift keeps the sign
			rvPkg::aluSrl: aluOut = exAltOp ? $unsigned($signed(opA) >>> srcB[4:0]) :
				opA >> srcB[4:0];
			rvPkg::aluOr: aluOut = opA | srcB;
			rvPkg::aluAnd: aluOut = opA & srcB;
		endcase
	end

	// decode checks this for the load-use hazard
	assign loadInExec = {exMemRead, exRd};

	always_ff @(posedge clk) begin
		if (!reset) begin
			memPort.valid <= 1'b0;
			memPort.regWrite <= 1'b0;
			memPort.memRead <= 1'b0;
			memPort.memWrite <= 1'b0;
		end else if (!memPort.stall) begin
			memPort.valid <= exValid;
			memPort.regWrite <= exRegWrite;
			memPort.memRead <= exMemRead;
			memPort.memWrite <= exMemWrite;
		end
	end

	// lui passes the upper immediate unchanged
	always_ff @(posedge clk) begin
		if (!memPort.stall) begin
			memPort.funct3 <= exFunct3;
			memPort.rd <= exRd;
			memPort.aluResult <= exIsLui ? exImm : aluOut;
			memPort.storeData <= opB;
		end
	end

endmodule

`default_nettype wire

// ==== hw/intCore.sv ====
// RV32I integer pipeline top level
// decode, execute and memory stages with instruction, APB and retire ports
`timescale 1ns/1ps
`default_nettype none

module intCore (
	input logic clk,
	input logic reset,
	input logic [rvPkg::xlen-1:0] instr,
	input logic instrValid,
	output logic instrReady,
	output logic [rvPkg::xlen-1:0] paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [rvPkg::xlen-1:0] pwdata,
	output logic [3:0] pstrb,
	input logic [rvPkg::xlen-1:0] prdata,
	input logic pready,
	output logic retireValid,
	output logic [rvPkg::regAddrW-1:0] retireRd,
	output logic [rvPkg::xlen-1:0] retireData
);

	exMemIf exMem ();
	memWbIf memWb ();

	// decode to execute operands and controls
	logic exValid, exRegWrite, exMemRead, exMemWrite;
	logic exUseImm, exIsLui, exAltOp;
	logic [2:0] exAluSel, exFunct3;
	logic [rvPkg::regAddrW-1:0] exRs1, exRs2, exRd;
	logic [rvPkg::xlen-1:0] exRs1Data, exRs2Data, exImm;
	logic [rvPkg::regAddrW:0] loadInExec;

	decodeStage uDecode (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.loadInExec(loadInExec),
		.memStall(exMem.stall),
		.wbPort(memWb.sink),
		.exValid(exValid),
		.exRegWrite(exRegWrite),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exUseImm(exUseImm),
		.exIsLui(exIsLui),
		.exAluSel(exAluSel),
		.exAltOp(exAltOp),
		.exFunct3(exFunct3),
		.exRs1(exRs1),
		.exRs2(exRs2),
		.exRd(exRd),
		.exRs1Data(exRs1Data),
		.exRs2Data(exRs2Data),
		.exImm(exImm)
	);

	execStage uExec (
		.clk(clk),
		.reset(reset),
		.exValid(exValid),
		.exRegWrite(exRegWrite),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exUseImm(exUseImm),
		.exIsLui(exIsLui),
		.exAluSel(exAluSel),
		.exAltOp(exAltOp),
		.exFunct3(exFunct3),
		.exRs1(exRs1),
		.exRs2(exRs2),
		.exRd(exRd),
		.exRs1Data(exRs1Data),
		.exRs2Data(exRs2Data),
		.exImm(exImm),
		.memPort(exMem.source),
		.wbPort(memWb.sink),
		.loadInExec(loadInExec)
	);

	memStage uMem (
		.clk(clk),
		.reset(reset),
		.memPort(exMem.sink),
		.wbPort(memWb.source),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready)
	);

	// one pulse per instruction that writes a real register
	assign retireValid = memWb.valid && memWb.regWrite && (memWb.rd != '0);
	assign retireRd = memWb.rd;
	assign retireData = memWb.result;

endmodule

`default_nettype wire

// ==== hw/lsCompute.svh ====
// load/store lane helpers for the memory stage
// load extraction with sign/zero extension, store lane placement and strobes
`ifndef LSCOMPUTE_SVH
`define LSCOMPUTE_SVH

// pick the addressed byte or half out of the bus word and extend it
function automatic logic [31:0] lsLoad(
	input logic [2:0] funct3,
	input logic [1:0] addrLo,
	input logic [31:0] rdata
);
	logic [31:0] shifted;
	shifted = rdata >> {addrLo, 3'b000};
	case (funct3)
		rvPkg::f3Byte: lsLoad = {{24{shifted[7]}}, shifted[7:0]};
		rvPkg::f3Half: lsLoad = {{16{shifted[15]}}, shifted[15:0]};
		rvPkg::f3ByteU: lsLoad = {24'b0, shifted[7:0]};
		rvPkg::f3HalfU: lsLoad = {16'b0, shifted[15:0]};
		default: lsLoad = rdata;
	endcase
endfunction

// move store data into the lanes selected by the low address bits
function automatic logic [31:0] lsStoreData(
	input logic [2:0] funct3,
	input logic [1:0] addrLo,
	input logic [31:0] data
);
	case (funct3)
		rvPkg::f3Byte: lsStoreData = {24'b0, data[7:0]} << {addrLo, 3'b000};
		rvPkg::f3Half: lsStoreData = {16'b0, data[15:0]} << {addrLo, 3'b000};
		default: lsStoreData = data;
	endcase
endfunction

// byte strobes matching the placed lanes
function automatic logic [3:0] lsStoreStrb(
	input logic [2:0] funct3,
	input logic [1:0] addrLo
);
	case (funct3)
		rvPkg::f3Byte: lsStoreStrb = 4'b0001 << addrLo;
		rvPkg::f3Half: lsStoreStrb = 4'b0011 << addrLo;
		default: lsStoreStrb = 4'b1111;
	endcase
endfunction

`endif

// ==== hw/memStage.sv ====
// memory stage: APB master for loads and stores and the writeback register
// holds the pipeline from the arrival of a memory op until its transfer completes
`timescale 1ns/1ps
`default_nettype none

module memStage (
	input logic clk,
	input logic reset,
	exMemIf.sink memPort,
	memWbIf.source wbPort,
	output logic [rvPkg::xlen-1:0] paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [rvPkg::xlen-1:0] pwdata,
	output logic [3:0] pstrb,
	input logic [rvPkg::xlen-1:0] prdata,
	input logic pready
);

	`include "lsCompute.svh"

	typedef enum logic {
		apbIdle,
		apbAccess
	} apbStateT;

	apbStateT apbState;
	logic memOp, done, xferDone;
	logic [rvPkg::xlen-1:0] loadQ;

	// xferDone marks the op as finished for the one cycle it takes to leave
	assign memOp = memPort.valid && (memPort.memRead || memPort.memWrite) && !xferDone;
	assign done = (apbState == apbAccess) && pready;
	assign memPort.stall = memOp;

	// setup cycle is psel with penable low
	assign psel = memOp;
	assign penable = apbState == apbAccess;
	assign pwrite = memPort.memWrite;
	assign paddr = memPort.aluResult;
	assign pwdata = lsStoreData(memPort.funct3, memPort.aluResult[1:0], memPort.storeData);
	// reads carry no strobes
	assign pstrb = memPort.memWrite ? lsStoreStrb(memPort.funct3, memPort.aluResult[1:0]) :
		4'b0000;

	always_ff @(posedge clk) begin
		if (!reset) begin
			apbState <= apbIdle;
			xferDone <= 1'b0;
		end else begin
			xferDone <= done;
			case (apbState)
				apbIdle: if (memOp) apbState <= apbAccess;
				apbAccess: if (pready) apbState <= apbIdle;
			endcase
		end
	end

	// extracted load data, taken on the completing edge
	always_ff @(posedge clk) begin
		if (done) begin
			loadQ <= lsLoad(memPort.funct3, memPort.aluResult[1:0], prdata);
		end
	end

	// valid is a single pulse, regWrite stays so execute can still forward
	always_ff @(posedge clk) begin
		if (!reset) begin
			wbPort.valid <= 1'b0;
			wbPort.regWrite <= 1'b0;
		end else if (memPort.stall) begin
			wbPort.valid <= 1'b0;
		end else begin
			wbPort.valid <= memPort.valid;
			wbPort.regWrite <= memPort.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!memPort.stall) begin
			wbPort.rd <= memPort.rd;
			wbPort.result <= memPort.memRead ? loadQ : memPort.aluResult;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pipeIf.sv ====
// pipeline stage interfaces
// execute-to-memory and memory-to-writeback bundles
`timescale 1ns/1ps
`default_nettype none

interface exMemIf;
	logic valid;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic [2:0] funct3;
	logic [rvPkg::regAddrW-1:0] rd;
	logic [rvPkg::xlen-1:0] aluResult;
	logic [rvPkg::xlen-1:0] storeData;
	// back pressure from the memory stage
	logic stall;

	modport source (
		output valid, regWrite, memRead, memWrite, funct3, rd, aluResult, storeData,
		input stall
	);
	modport sink (
		input valid, regWrite, memRead, memWrite, funct3, rd, aluResult, storeData,
		output stall
	);
endinterface

interface memWbIf;
	// valid pulses once per instruction, the rest stays for forwarding
	logic valid;
	logic regWrite;
	logic [rvPkg::regAddrW-1:0] rd;
	logic [rvPkg::xlen-1:0] result;

	modport source (
		output valid, regWrite, rd, result
	);
	modport sink (
		input valid, regWrite, rd, result
	);
endinterface

`default_nettype wire

// ==== hw/regFile.sv ====
// integer register file, two read ports and one write port
// x0 reads as zero, a same-cycle write is bypassed to the readers
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input logic clk,
	input logic reset,
	input logic [rvPkg::regAddrW-1:0] rs1,
	input logic [rvPkg::regAddrW-1:0] rs2,
	input logic writeEn,
	input logic [rvPkg::regAddrW-1:0] writeAddr,
	input logic [rvPkg::xlen-1:0] writeData,
	output logic [rvPkg::xlen-1:0] rs1Data,
	output logic [rvPkg::xlen-1:0] rs2Data
);

	logic [rvPkg::xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// x0 first, then the value being written this cycle
	assign rs1Data = (rs1 == '0) ? '0 :
		(writeEn && writeAddr == rs1) ? writeData : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 :
		(writeEn && writeAddr == rs2) ? writeData : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/rvPkg.sv ====
// RV32I integer core shared definitions
// opcodes, access widths, ALU selects and the decoded instruction word
`default_nettype none

package rvPkg;

	// data path and register index widths
	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// supported opcode classes
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;

	// load/store width and sign, straight from funct3
	localparam logic [2:0] f3Byte = 3'b000;
	localparam logic [2:0] f3Half = 3'b001;
	localparam logic [2:0] f3Word = 3'b010;
	localparam logic [2:0] f3ByteU = 3'b100;
	localparam logic [2:0] f3HalfU = 3'b101;

	// ALU selects equal funct3, altOp turns add into sub and srl into sra
	localparam logic [2:0] aluAdd = 3'b000;
	localparam logic [2:0] aluSll = 3'b001;
	localparam logic [2:0] aluSlt = 3'b010;
	localparam logic [2:0] aluSltu = 3'b011;
	localparam logic [2:0] aluXor = 3'b100;
	localparam logic [2:0] aluSrl = 3'b101;
	localparam logic [2:0] aluOr = 3'b110;
	localparam logic [2:0] aluAnd = 3'b111;

	// I-type layout, also used for OP and LUI fields
	typedef struct packed {
		logic [11:0] imm;
		logic [regAddrW-1:0] rs1;
		logic [2:0] funct3;
		logic [regAddrW-1:0] rd;
		logic [6:0] opcode;
	} iFields;

	// S-type layout, gives rs2 for OP and stores
	typedef struct packed {
		logic [6:0] immHi;
		logic [regAddrW-1:0] rs2;
		logic [regAddrW-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFields;

	// one instruction word, two ways to read it
	typedef union packed {
		iFields iView;
		sFields sView;
	} instrWord;

endpackage

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/rvPkg.sv
hw/pipeIf.sv
hw/regFile.sv
hw/decodeStage.sv
hw/execStage.sv
hw/memStage.sv
hw/intCore.sv
verif/intCore_properties.sv
verif/intCoreTb.sv

// ==== verif/intCoreTb.sv ====
// testbench for the RV32I integer pipeline
// random program, APB memory model and an architectural reference model
`timescale 1ns/1ps
`default_nettype none

module intCoreTb;

	localparam int progLen = 400;
	localparam int timeoutCycles = progLen * 10 + 100;
	localparam int memBytes = 256;
	localparam int numTests = 6;
	localparam int tAlu = 0;
	localparam int tFwd = 1;
	localparam int tLoad = 2;
	localparam int tStore = 3;
	localparam int tZeroLui = 4;
	localparam int tDone = 5;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic instrValid;
	logic instrReady;
	logic [31:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [3:0] pstrb;
	logic [31:0] prdata;
	logic pready;
	logic retireValid;
	logic [4:0] retireRd;
	logic [31:0] retireData;

	integer seed;
	int cycles;
	int issued;
	int retired;
	int expectedRetires;
	int apbWait;
	int totalChecks;
	int totalErrors;
	bit holding;
	logic [31:0] curInstr;

	// architectural state of the reference model
	logic [31:0] refRegs [32];
	logic [7:0] refMem [memBytes];
	// backing store behind the APB slave that starts equal to refMem
	logic [7:0] slaveMem [memBytes];
	// rd of the last three instructions used to tag dependent ones
	logic [4:0] recentRd [3];

	// expected retirements in program order
	logic [4:0] expRd [$];
	logic [31:0] expVal [$];
	int expTest [$];
	// expected APB transfers in program order
	logic [31:0] apbAddrQ [$];
	logic apbWriteQ [$];
	logic [3:0] apbStrbQ [$];
	logic [31:0] apbDataQ [$];

	string testName [numTests];
	int checks [numTests];
	int errors [numTests];

	intCore u_dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.retireValid(retireValid),
		.retireRd(retireRd),
		.retireData(retireData)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic int unsigned randBelow(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic int accessBytes(input logic [2:0] f3);
		case (f3[1:0])
			2'b00: return 1;
			2'b01: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic bit dependsOn(input logic [4:0] r);
		return r != 5'd0 && (r == recentRd[0] || r == recentRd[1] || r == recentRd[2]);
	endfunction

	// RV32I integer semantics where alt marks sub and sra
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkValue(input int t, input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks[t]++;
		if (expected !== actual) begin
			errors[t]++;
			$display("CHECK FAILED %s (%s): expected %h actual %h", testName[t], what,
				expected, actual);
		end
	endtask

	task automatic reportProblem(input int t, input string msg);
		errors[t]++;
		$display("%s: %s", testName[t], msg);
	endtask

	// random instruction with registers limited to x0..x7 to force hazards
	task automatic genInstr(output logic [31:0] ins);
		int kind;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] shamt;
		logic [11:0] imm;
		logic [7:0] addr;
		logic alt;
		kind = int'(randBelow(20));
		f3 = 3'(randBelow(8));
		rd = 5'(randBelow(8));
		rs1 = 5'(randBelow(8));
		rs2 = 5'(randBelow(8));
		shamt = 5'(randBelow(32));
		alt = 1'(randBelow(2));
		imm = 12'($random(seed));
		addr = 8'(randBelow(memBytes));
		if (kind < 6) begin
			ins = {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd,
				rvPkg::opOp};
		end else if (kind < 12) begin
			if (f3 == 3'b001) begin
				imm = {7'b0, shamt};
			end else if (f3 == 3'b101) begin
				imm = {1'b0, alt, 5'b0, shamt};
			end
			ins = {imm, rs1, f3, rd, rvPkg::opImm};
		end else if (kind < 14) begin
			ins = {20'($random(seed)), rd, rvPkg::opLui};
		end else if (kind < 17) begin
			case (randBelow(5))
				0: f3 = rvPkg::f3Byte;
				1: f3 = rvPkg::f3Half;
				2: f3 = rvPkg::f3Word;
				3: f3 = rvPkg::f3ByteU;
				default: f3 = rvPkg::f3HalfU;
			endcase
			if (accessBytes(f3) == 2) begin
				addr[0] = 1'b0;
			end else if (accessBytes(f3) == 4) begin
				addr[1:0] = 2'b00;
			end
			// base x0, so the immediate is the address
			ins = {4'b0, addr, 5'b0, f3, rd, rvPkg::opLoad};
		end else begin
			case (randBelow(3))
				0: f3 = rvPkg::f3Byte;
				1: f3 = rvPkg::f3Half;
				default: f3 = rvPkg::f3Word;
			endcase
			if (accessBytes(f3) == 2) begin
				addr[0] = 1'b0;
			end else if (accessBytes(f3) == 4) begin
				addr[1:0] = 2'b00;
			end
			ins = {4'b0, addr[7:5], rs2, 5'b0, f3, addr[4:0], rvPkg::opStore};
		end
	endtask

	// executes on acceptance, queues retire values and APB transfers
	task automatic modelExecute(input logic [31:0] ins);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] eaddr;
		logic [31:0] raw;
		logic [31:0] lanes;
		logic [31:0] result;
		logic [3:0] strb;
		int addr;
		int width;
		int lane;
		int test;
		bit writes;
		rd = ins[11:7];
		f3 = ins[14:12];
		rs1 = ins[19:15];
		rs2 = ins[24:20];
		a = refRegs[rs1];
		b = refRegs[rs2];
		writes = 1'b0;
		result = '0;
		raw = '0;
		lanes = '0;
		strb = '0;
		test = tAlu;
		width = accessBytes(f3);
		case (ins[6:0])
			rvPkg::opOp: begin
				writes = 1'b1;
				result = refAlu(f3, ins[30], a, b);
				if (dependsOn(rs1) || dependsOn(rs2)) begin
					test = tFwd;
				end
			end
			rvPkg::opImm: begin
				writes = 1'b1;
				// only srai carries the arithmetic bit
				result = refAlu(f3, ins[30] && f3 == 3'b101, a, {{20{ins[31]}}, ins[31:20]});
				if (dependsOn(rs1)) begin
					test = tFwd;
				end
			end
			rvPkg::opLui: begin
				writes = 1'b1;
				result = {ins[31:12], 12'b0};
				test = tZeroLui;
			end
			rvPkg::opLoad: begin
				writes = 1'b1;
				test = tLoad;
				eaddr = a + {{20{ins[31]}}, ins[31:20]};
				addr = {24'b0, eaddr[7:0]};
				// little endian so the byte at addr is the low byte
				for (int i = 0; i < width; i++) begin
					raw[i*8 +: 8] = refMem[addr + i];
				end
				if (!f3[2] && width == 1) begin
					result = {{24{raw[7]}}, raw[7:0]};
				end else if (!f3[2] && width == 2) begin
					result = {{16{raw[15]}}, raw[15:0]};
				end else begin
					result = raw;
				end
				apbAddrQ.push_back(eaddr);
				apbWriteQ.push_back(1'b0);
				apbStrbQ.push_back(4'b0000);
				apbDataQ.push_back('0);
			end
			default: begin
				eaddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				addr = {24'b0, eaddr[7:0]};
				for (int i = 0; i < width; i++) begin
					lane = (addr + i) % 4;
					strb[lane] = 1'b1;
					lanes[lane*8 +: 8] = b[i*8 +: 8];
					refMem[addr + i] = b[i*8 +: 8];
				end
				apbAddrQ.push_back(eaddr);
				apbWriteQ.push_back(1'b1);
				apbStrbQ.push_back(strb);
				apbDataQ.push_back(lanes);
			end
		endcase
		recentRd[2] = recentRd[1];
		recentRd[1] = recentRd[0];
		recentRd[0] = writes ? rd : 5'd0;
		// x0 stays zero and produces no retire
		if (writes && rd != 5'd0) begin
			refRegs[rd] = result;
			expRd.push_back(rd);
			expVal.push_back(result);
			expTest.push_back(test);
			expectedRetires++;
		end
	endtask

	task automatic checkRetire();
		logic [4:0] rd;
		logic [31:0] val;
		int t;
		if (retireValid) begin
			retired++;
			checks[tZeroLui]++;
			if (retireRd == '0) begin
				reportProblem(tZeroLui, "retire pulse for a write to x0");
			end
			if (expRd.size() == 0) begin
				reportProblem(tDone, "retire pulse with no instruction outstanding");
			end else begin
				rd = expRd.pop_front();
				val = expVal.pop_front();
				t = expTest.pop_front();
				checkValue(tFwd, "retire order rd", {27'b0, rd}, {27'b0, retireRd});
				checkValue(t, "retire data", val, retireData);
			end
		end
	endtask

	// check one APB request, then update or read slaveMem
	task automatic completeApb();
		logic [31:0] expAddr;
		logic [31:0] expData;
		logic [31:0] mask;
		logic [3:0] expStrb;
		logic expWrite;
		int base;
		int t;
		if (apbAddrQ.size() == 0) begin
			reportProblem(tDone, "APB transfer with no memory instruction pending");
			prdata = '0;
		end else begin
			expAddr = apbAddrQ.pop_front();
			expWrite = apbWriteQ.pop_front();
			expStrb = apbStrbQ.pop_front();
			expData = apbDataQ.pop_front();
			t = expWrite ? tStore : tLoad;
			checkValue(t, "apb address", expAddr, paddr);
			checkValue(t, "apb write", {31'b0, expWrite}, {31'b0, pwrite});
			checkValue(t, "apb strobes", {28'b0, expStrb}, {28'b0, pstrb});
			if (paddr >= memBytes) begin
				reportProblem(t, "APB address outside the memory window");
			end
			base = {24'b0, paddr[7:2], 2'b00};
			if (pwrite) begin
				// only strobed lanes carry data
				for (int i = 0; i < 4; i++) begin
					mask[i*8 +: 8] = {8{expStrb[i]}};
					if (pstrb[i]) begin
						slaveMem[base + i] = pwdata[i*8 +: 8];
					end
				end
				checkValue(tStore, "apb write data", expData & mask, pwdata & mask);
			end
			prdata = {slaveMem[base + 3], slaveMem[base + 2], slaveMem[base + 1],
				slaveMem[base]};
		end
	endtask

	// slave inserts 0 to 3 wait cycles per access
	task automatic serveApb();
		if (psel && !penable) begin
			apbWait = int'(randBelow(4));
			pready = 1'b0;
		end else if (psel && penable && apbWait > 0) begin
			apbWait--;
			pready = 1'b0;
		end else if (psel && penable) begin
			completeApb();
			pready = 1'b1;
		end else begin
			pready = 1'b0;
		end
	endtask

	// instrReady does not depend on instr or instrValid, so it is settled here
	task automatic driveInstr();
		if (!holding && issued < progLen && randBelow(8) != 0) begin
			genInstr(curInstr);
			holding = 1'b1;
		end
		instrValid = holding;
		instr = curInstr;
		if (holding && instrReady) begin
			modelExecute(curInstr);
			issued++;
			holding = 1'b0;
		end
	endtask

	task automatic cycleStep();
		@(posedge clk);
		#1;
		checkRetire();
		serveApb();
		driveInstr();
	endtask

	initial begin
		cycles = 0;
		while (cycles < timeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d of %0d instructions issued", cycles,
			issued, progLen);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'hce90a4ce;
		reset = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		prdata = '0;
		pready = 1'b0;
		holding = 1'b0;
		curInstr = '0;
		issued = 0;
		retired = 0;
		expectedRetires = 0;
		apbWait = 0;
		totalChecks = 0;
		totalErrors = 0;
		testName[tAlu] = "alu";
		testName[tFwd] = "forwarding";
		testName[tLoad] = "loads";
		testName[tStore] = "stores";
		testName[tZeroLui] = "x0_lui";
		testName[tDone] = "completion";
		for (int i = 0; i < numTests; i++) begin
			checks[i] = 0;
			errors[i] = 0;
		end
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		for (int i = 0; i < 3; i++) begin
			recentRd[i] = '0;
		end
		for (int i = 0; i < memBytes; i++) begin
			refMem[i] = 8'($random(seed));
			slaveMem[i] = refMem[i];
		end
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b1;
		while (issued < progLen || expRd.size() != 0 || apbAddrQ.size() != 0) begin
			cycleStep();
		end
		// idle tail catches stray retire pulses
		repeat (10) begin
			cycleStep();
		end
		checkValue(tDone, "retire count", expectedRetires, retired);
		if (u_dut.uProps.failCount != 0) begin
			reportProblem(tDone, "APB or pipeline assertions failed");
		end
		for (int i = 0; i < numTests; i++) begin
			$display("%s: %0d checks, %0d errors, %s", testName[i], checks[i], errors[i],
				errors[i] == 0 ? "ok" : "FAILED");
			totalChecks += checks[i];
			totalErrors += errors[i];
		end
		$display("%0d tests, %0d checks, %0d errors", numTests, totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/intCore_properties.sv ====
// APB and pipeline assertions for the integer core
// bound into intCore
`timescale 1ns/1ps
`default_nettype none

module intCoreProperties (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	input logic [3:0] pstrb,
	input logic instrReady
);

	int failCount = 0;

	// access phase only inside a selected transfer
	penableWithPsel: assert property (@(posedge clk) disable iff (!reset)
		penable |-> psel)
	else begin
		failCount++;
		$error("penable high without psel");
	end

	// setup and wait cycles keep the whole request steady
	apbRequestHeld: assert property (@(posedge clk) disable iff (!reset)
		(psel && !(penable && pready)) |=>
		(psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata) && $stable(pstrb)))
	else begin
		failCount++;
		$error("APB request changed before completion");
	end

	// a memory access freezes the front of the pipe
	noIssueDuringApb: assert property (@(posedge clk) disable iff (!reset)
		psel |-> !instrReady)
	else begin
		failCount++;
		$error("instrReady high during an APB transfer");
	end

endmodule

bind intCore intCoreProperties uProps (
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.pready(pready),
	.paddr(paddr),
	.pwdata(pwdata),
	.pstrb(pstrb),
	.instrReady(instrReady)
);

`default_nettype wire
